/* sources.f */
+incdir+.
wb_cdc_pkg.sv
ff_mb_sync.sv
wb_cross_clk.sv
wb_slave_ram.sv
wb_cdc_top.sv
wb_cdc_assertions.sv
tb_wb_cdc.sv

/* tb_wb_cdc.sv */
`timescale 1ns/1ps
`include "wb_cdc_config.svh"

module tb_wb_cdc;
    import wb_cdc_pkg::*;

    localparam int RAM_WORDS    = 1 << `RAM_DEPTH_LOG;
    localparam int RESET_CYCLES = 16;
    localparam int IGNORE_HOLD  = 60;
    localparam int N_SINGLE     = 12;
    localparam int N_LANE       = 4;
    localparam int N_BURST      = 3;
    localparam int N_BWR        = 2;
    localparam int N_OOR        = 3;
    // Ignored-window read and the final sweep are the last two terms.
    localparam int TOTAL_BEATS  = 2*N_SINGLE + 4*N_LANE + N_BURST*(4 + 8) + 2*N_BWR
                                  + 2*N_OOR + 1 + RAM_WORDS;
    localparam int TIMEOUT_CYCLES = 40*TOTAL_BEATS + RESET_CYCLES;
    localparam wb_addr_t BASE   = wb_addr_t'(`IGNORED_ADDR_LIMIT);

    logic     clk_m = 1'b0;
    logic     clk_s = 1'b0;
    logic     m_rst;
    logic     s_rst;
    logic     m_wb_cyc;
    logic     m_wb_stb;
    wb_addr_t m_wb_adr;
    wb_data_t m_wb_o_dat;
    logic     m_wb_we;
    wb_sel_t  m_wb_sel;
    logic     m_wb_4_burst;
    logic     m_wb_8_burst;
    wb_data_t m_wb_i_dat;
    logic     m_wb_ack;
    logic     m_wb_err;

    wb_data_t shadow [RAM_WORDS];
    wb_data_t exp_dat_q [$];
    logic     exp_bad_q [$];
    logic     exp_rd_q [$];  // Data is only compared on in-range reads.
    int       cycles = 0;

    always #20 clk_m = ~clk_m;
    always #100 clk_s = ~clk_s;

    wb_cdc_top i_dut (
        .clk_m        (clk_m),
        .clk_s        (clk_s),
        .m_rst        (m_rst),
        .s_rst        (s_rst),
        .m_wb_cyc     (m_wb_cyc),
        .m_wb_stb     (m_wb_stb),
        .m_wb_adr     (m_wb_adr),
        .m_wb_o_dat   (m_wb_o_dat),
        .m_wb_we      (m_wb_we),
        .m_wb_sel     (m_wb_sel),
        .m_wb_4_burst (m_wb_4_burst),
        .m_wb_8_burst (m_wb_8_burst),
        .m_wb_i_dat   (m_wb_i_dat),
        .m_wb_ack     (m_wb_ack),
        .m_wb_err     (m_wb_err)
    );

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Run stopped at first error.");
    endtask

    task automatic check_data(input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            $display("ERR %0t: read data got %h expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_resp(input logic got_ack, input logic got_err, input logic exp_err);
        if (got_err !== exp_err || got_ack !== !exp_err) begin
            $display("ERR %0t: response got ack=%0b err=%0b expected err=%0b", $time,
                     got_ack, got_err, exp_err);
            abort_run();
        end
    endtask

    // Expected result of one beat; writes update the shadow copy.
    function automatic wb_data_t ref_access(input wb_addr_t adr, input logic we,
            input wb_sel_t sel, input wb_data_t dat, input logic b4, input logic b8,
            input int beat, output logic bad);
        wb_addr_t a;
        wb_addr_t span;
        int       idx;
        span = 1;
        if (!we && b8) span = 8;
        else if (!we && b4) span = 4;
        a   = adr - (adr % span) + ((adr % span + beat) % span); // Wrap in aligned block.
        bad = (a < BASE) || (a >= BASE + RAM_WORDS);
        if (bad) begin
            return '0;
        end
        idx = int'(a - BASE);
        if (we && sel[0]) shadow[idx][7:0] = dat[7:0];
        if (we && sel[1]) shadow[idx][15:8] = dat[15:8];
        return shadow[idx];
    endfunction

    function automatic wb_addr_t rand_in_range();
        return BASE + wb_addr_t'($urandom % RAM_WORDS);
    endfunction

    task automatic wb_access(input wb_addr_t adr, input logic we, input wb_sel_t sel,
                             input wb_data_t dat, input logic b4, input logic b8);
        int       beats;
        int       seen;
        wb_data_t exp_dat;
        logic     exp_bad;
        beats = we ? 1 : (b8 ? 8 : (b4 ? 4 : 1));
        seen  = 0;
        for (int k = 0; k < beats; k++) begin
            exp_dat = ref_access(adr, we, sel, dat, b4, b8, k, exp_bad);
            exp_dat_q.push_back(exp_dat);
            exp_bad_q.push_back(exp_bad);
            exp_rd_q.push_back(!we && !exp_bad);
        end
        @(posedge clk_m);
        m_wb_cyc     <= 1'b1;
        m_wb_stb     <= 1'b1;
        m_wb_adr     <= adr;
        m_wb_o_dat   <= dat;
        m_wb_we      <= we;
        m_wb_sel     <= sel;
        m_wb_4_burst <= b4;
        m_wb_8_burst <= b8;
        while (seen < beats) begin
            @(posedge clk_m);
            if (m_wb_ack || m_wb_err) seen++;
        end
        m_wb_cyc     <= 1'b0; // Drop right after the last response.
        m_wb_stb     <= 1'b0;
        m_wb_4_burst <= 1'b0;
        m_wb_8_burst <= 1'b0;
        @(posedge clk_m);
    endtask

    // Request below the window; the compare process flags any response.
    task automatic ignored_hold(input wb_addr_t adr);
        @(posedge clk_m);
        m_wb_cyc <= 1'b1;
        m_wb_stb <= 1'b1;
        m_wb_adr <= adr;
        m_wb_we  <= 1'b0;
        m_wb_sel <= 2'b11;
        repeat (IGNORE_HOLD) @(posedge clk_m);
        m_wb_cyc <= 1'b0;
        m_wb_stb <= 1'b0;
        @(posedge clk_m);
    endtask

    always @(posedge clk_m) begin : resp_compare
        wb_data_t exp_dat;
        logic     exp_bad;
        logic     exp_rd;
        if (m_wb_ack || m_wb_err) begin
            if (exp_bad_q.size() == 0) begin
                $display("Response pulse at %0t with no request pending.", $time);
                abort_run();
            end else begin
                exp_dat = exp_dat_q.pop_front();
                exp_bad = exp_bad_q.pop_front();
                exp_rd  = exp_rd_q.pop_front();
                check_resp(m_wb_ack, m_wb_err, exp_bad);
                if (exp_rd) check_data(m_wb_i_dat, exp_dat);
            end
        end
    end

    always @(posedge clk_m) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d clk_m cycles, a transfer never finished.", cycles);
            abort_run();
        end
    end

    initial begin : stimulus
        wb_addr_t adr;
        wb_data_t dat;
        void'($urandom(32'hab25));
        for (int i = 0; i < RAM_WORDS; i++) begin
            shadow[i] = '0;  // Slave memory resets to zero.
        end
        m_rst        = 1'b1;
        s_rst        = 1'b1;
        m_wb_cyc     = 1'b0;
        m_wb_stb     = 1'b0;
        m_wb_adr     = '0;
        m_wb_o_dat   = '0;
        m_wb_we      = 1'b0;
        m_wb_sel     = '0;
        m_wb_4_burst = 1'b0;
        m_wb_8_burst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_m);
        m_rst <= 1'b0;
        s_rst <= 1'b0;
        repeat (2) @(posedge clk_m);

        for (int i = 0; i < N_SINGLE; i++) begin
            adr = rand_in_range();
            dat = wb_data_t'($urandom);
            wb_access(adr, 1'b1, 2'b11, dat, 1'b0, 1'b0);
            wb_access(adr, 1'b0, 2'b11, '0, 1'b0, 1'b0);
        end
        for (int i = 0; i < N_LANE; i++) begin
            adr = rand_in_range();
            wb_access(adr, 1'b1, 2'b01, wb_data_t'($urandom), 1'b0, 1'b0);
            wb_access(adr, 1'b0, 2'b11, '0, 1'b0, 1'b0);
            wb_access(adr, 1'b1, 2'b10, wb_data_t'($urandom), 1'b0, 1'b0);
            wb_access(adr, 1'b0, 2'b11, '0, 1'b0, 1'b0);
        end
        for (int i = 0; i < N_BURST; i++) begin
            wb_access(rand_in_range(), 1'b0, 2'b11, '0, 1'b1, 1'b0);
            wb_access(rand_in_range(), 1'b0, 2'b11, '0, 1'b0, 1'b1);
        end
        for (int i = 0; i < N_BWR; i++) begin
            adr = rand_in_range();
            wb_access(adr, 1'b1, 2'b11, wb_data_t'($urandom), i[0], ~i[0]);
            wb_access(adr, 1'b0, 2'b11, '0, 1'b0, 1'b0);
        end
        for (int i = 0; i < N_OOR; i++) begin
            adr = BASE + RAM_WORDS + wb_addr_t'($urandom % 'h1000);
            wb_access(adr, 1'b1, 2'b11, wb_data_t'($urandom), 1'b0, 1'b0);
            wb_access(adr, 1'b0, 2'b11, '0, 1'b0, 1'b0);
        end
        ignored_hold(wb_addr_t'($urandom % `IGNORED_ADDR_LIMIT));
        wb_access(rand_in_range(), 1'b0, 2'b11, '0, 1'b0, 1'b0);
        // Full sweep catches any stray write.
        for (int i = 0; i < RAM_WORDS; i++) begin
            wb_access(BASE + wb_addr_t'(i), 1'b0, 2'b11, '0, 1'b0, 1'b0);
        end

        repeat (4) @(posedge clk_m);
        if (exp_bad_q.size() == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            $display("Run ended with %0d responses still missing.", exp_bad_q.size());
            abort_run();
        end
    end

endmodule

/* wb_cdc_assertions.sv */
`timescale 1ns/1ps

// Master port protocol checks on the bridge.
module wb_cdc_assertions (
    input logic clk_m,
    input logic m_rst,
    input logic m_wb_cyc,
    input logic m_wb_stb,
    input logic m_wb_ack,
    input logic m_wb_err
);

    property ack_err_exclusive;
        @(posedge clk_m) disable iff (m_rst) !(m_wb_ack && m_wb_err);
    endproperty

    // Second reset cycle onward, once the bridge flops have cleared.
    property quiet_in_reset;
        @(posedge clk_m) m_rst ##1 m_rst |-> !(m_wb_ack || m_wb_err);
    endproperty

    property ack_needs_stb;
        @(posedge clk_m) disable iff (m_rst) m_wb_ack |-> (m_wb_cyc && m_wb_stb);
    endproperty

    a_ack_err_exclusive: assert property (ack_err_exclusive)
        else $error("m_wb_ack and m_wb_err high in the same cycle.");
    a_quiet_in_reset: assert property (quiet_in_reset)
        else $error("Response pulse while m_rst is high.");
    a_ack_needs_stb: assert property (ack_needs_stb)
        else $error("m_wb_ack without an active strobe.");

endmodule

bind wb_cross_clk wb_cdc_assertions i_assert (
    .clk_m    (clk_m),
    .m_rst    (m_rst),
    .m_wb_cyc (m_wb_cyc),
    .m_wb_stb (m_wb_stb),
    .m_wb_ack (m_wb_ack),
    .m_wb_err (m_wb_err)
);

/* wb_cdc_top.sv */
`timescale 1ns/1ps

module wb_cdc_top (
    input  logic                 clk_m,
    input  logic                 clk_s,
    input  logic                 m_rst,
    input  logic                 s_rst,

    input  logic                 m_wb_cyc,
    input  logic                 m_wb_stb,
    input  wb_cdc_pkg::wb_addr_t m_wb_adr,
    input  wb_cdc_pkg::wb_data_t m_wb_o_dat,
    input  logic                 m_wb_we,
    input  wb_cdc_pkg::wb_sel_t  m_wb_sel,
    input  logic                 m_wb_4_burst,
    input  logic                 m_wb_8_burst,
    output wb_cdc_pkg::wb_data_t m_wb_i_dat,
    output logic                 m_wb_ack,
    output logic                 m_wb_err
);
    import wb_cdc_pkg::*;

    // Slave side of the bridge, all in clk_s.
    logic     s_wb_cyc;
    logic     s_wb_stb;
    wb_addr_t s_wb_adr;
    wb_data_t s_wb_o_dat;
    logic     s_wb_we;
    wb_sel_t  s_wb_sel;
    logic     s_wb_4_burst;
    logic     s_wb_8_burst;
    wb_data_t s_wb_i_dat;
    logic     s_wb_ack;
    logic     s_wb_err;

    wb_cross_clk i_bridge (
        .clk_m        (clk_m),
        .clk_s        (clk_s),
        .m_rst        (m_rst),
        .s_rst        (s_rst),
        .m_wb_cyc     (m_wb_cyc),
        .m_wb_stb     (m_wb_stb),
        .m_wb_adr     (m_wb_adr),
        .m_wb_o_dat   (m_wb_o_dat),
        .m_wb_we      (m_wb_we),
        .m_wb_sel     (m_wb_sel),
        .m_wb_4_burst (m_wb_4_burst),
        .m_wb_8_burst (m_wb_8_burst),
        .m_wb_i_dat   (m_wb_i_dat),
        .m_wb_ack     (m_wb_ack),
        .m_wb_err     (m_wb_err),
        .s_wb_cyc     (s_wb_cyc),
        .s_wb_stb     (s_wb_stb),
        .s_wb_adr     (s_wb_adr),
        .s_wb_o_dat   (s_wb_o_dat),
        .s_wb_we      (s_wb_we),
        .s_wb_sel     (s_wb_sel),
        .s_wb_4_burst (s_wb_4_burst),
        .s_wb_8_burst (s_wb_8_burst),
        .s_wb_i_dat   (s_wb_i_dat),
        .s_wb_ack     (s_wb_ack),
        .s_wb_err     (s_wb_err)
    );

    wb_slave_ram i_ram (
        .clk_s        (clk_s),
        .s_rst        (s_rst),
        .s_wb_cyc     (s_wb_cyc),
        .s_wb_stb     (s_wb_stb),
        .s_wb_adr     (s_wb_adr),
        .s_wb_o_dat   (s_wb_o_dat),
        .s_wb_we      (s_wb_we),
        .s_wb_sel     (s_wb_sel),
        .s_wb_4_burst (s_wb_4_burst),
        .s_wb_8_burst (s_wb_8_burst),
        .s_wb_i_dat   (s_wb_i_dat),
        .s_wb_ack     (s_wb_ack),
        .s_wb_err     (s_wb_err)
    );

endmodule

/* wb_slave_ram.sv */
`timescale 1ns/1ps
`include "wb_cdc_config.svh"

// Register file slave in the clk_s domain, one ack or err per strobed cycle.
module wb_slave_ram (
    input  logic                 clk_s,
    input  logic                 s_rst,
    input  logic                 s_wb_cyc,
    input  logic                 s_wb_stb,
    input  wb_cdc_pkg::wb_addr_t s_wb_adr,
    input  wb_cdc_pkg::wb_data_t s_wb_o_dat,
    input  logic                 s_wb_we,
    input  wb_cdc_pkg::wb_sel_t  s_wb_sel,
    input  logic                 s_wb_4_burst,
    input  logic                 s_wb_8_burst,
    output wb_cdc_pkg::wb_data_t s_wb_i_dat,
    output logic                 s_wb_ack,
    output logic                 s_wb_err
);
    import wb_cdc_pkg::*;

    localparam int DEPTH = 1 << `RAM_DEPTH_LOG;

    wb_data_t                  mem [DEPTH];
    ram_state_t                state;
    burst_cnt_t                beat_off;
    burst_cnt_t                last_off;
    wb_addr_t                  beat_adr;
    wb_addr_t                  mem_off;
    logic [`RAM_DEPTH_LOG-1:0] mem_idx;
    logic                      in_range;
    logic                      beat_go;

    // Burst beats wrap inside the aligned block of the burst.
    always_comb begin
        beat_adr = s_wb_adr;
        if (!s_wb_we && s_wb_8_burst) begin
            beat_adr[2:0] = s_wb_adr[2:0] + beat_off[2:0];
        end else if (!s_wb_we && s_wb_4_burst) begin
            beat_adr[1:0] = s_wb_adr[1:0] + beat_off[1:0];
        end
    end

    assign last_off = s_wb_we      ? '0 :
                      s_wb_8_burst ? burst_cnt_t'(7) :
                      s_wb_4_burst ? burst_cnt_t'(3) : '0;

    assign mem_off  = beat_adr - wb_addr_t'(`IGNORED_ADDR_LIMIT);
    assign in_range = (beat_adr >= wb_addr_t'(`IGNORED_ADDR_LIMIT)) &&
                      (mem_off < wb_addr_t'(DEPTH));
    assign mem_idx  = mem_off[`RAM_DEPTH_LOG-1:0];
    assign beat_go  = s_wb_cyc & s_wb_stb & (state != RAM_HOLD);

    always_ff @(posedge clk_s) begin
        if (s_rst) begin
            state    <= RAM_IDLE;
            beat_off <= '0;
            s_wb_ack <= 1'b0;
            s_wb_err <= 1'b0;
        end else begin
            case (state)
                RAM_IDLE, RAM_ACK: begin
                    if (beat_go) begin
                        s_wb_ack <= in_range;
                        s_wb_err <= ~in_range;
                        if (beat_off == last_off) begin
                            beat_off <= '0;
                            state    <= RAM_HOLD;
                        end else begin
                            beat_off <= beat_off + 1'b1;
                            state    <= RAM_ACK;
                        end
                    end else begin
                        s_wb_ack <= 1'b0;
                        s_wb_err <= 1'b0;
                        beat_off <= '0;
                        state    <= RAM_IDLE;
                    end
                end
                default: begin
                    s_wb_ack <= 1'b0;
                    s_wb_err <= 1'b0;
                    if (!s_wb_stb) state <= RAM_IDLE; // Bridge has released stb.
                end
            endcase
        end
    end

    always_ff @(posedge clk_s) begin
        if (s_rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (beat_go && in_range && s_wb_we) begin
            for (int l = 0; l < $bits(wb_sel_t); l++) begin
                if (s_wb_sel[l]) mem[mem_idx][8*l +: 8] <= s_wb_o_dat[8*l +: 8];
            end
        end
    end

    always_ff @(posedge clk_s) begin
        if (beat_go && !s_wb_we) begin
            s_wb_i_dat <= mem[mem_idx];
        end
    end

endmodule

/* wb_cross_clk.sv */
`timescale 1ns/1ps
`include "wb_cdc_config.svh"

// Wishbone bridge from the clk_m master domain to the clk_s slave domain.
// clk_s must run at least five times slower than clk_m.
module wb_cross_clk (
    input  logic                 clk_m,
    input  logic                 clk_s,
    input  logic                 m_rst,
    input  logic                 s_rst,

    input  logic                 m_wb_cyc,
    input  logic                 m_wb_stb,
    input  wb_cdc_pkg::wb_addr_t m_wb_adr,
    input  wb_cdc_pkg::wb_data_t m_wb_o_dat,
    input  logic                 m_wb_we,
    input  wb_cdc_pkg::wb_sel_t  m_wb_sel,
    input  logic                 m_wb_4_burst,
    input  logic                 m_wb_8_burst,
    output wb_cdc_pkg::wb_data_t m_wb_i_dat,
    output logic                 m_wb_ack,
    output logic                 m_wb_err,

    output logic                 s_wb_cyc,
    output logic                 s_wb_stb,
    output wb_cdc_pkg::wb_addr_t s_wb_adr,
    output wb_cdc_pkg::wb_data_t s_wb_o_dat,
    output logic                 s_wb_we,
    output wb_cdc_pkg::wb_sel_t  s_wb_sel,
    output logic                 s_wb_4_burst,
    output logic                 s_wb_8_burst,
    input  wb_cdc_pkg::wb_data_t s_wb_i_dat,
    input  logic                 s_wb_ack,
    input  logic                 s_wb_err
);
    import wb_cdc_pkg::*;

    // cyc, adr, dat, we, sel, two burst bits, new-request flag.
    localparam int FWD_W = 1 + $bits(wb_addr_t) + $bits(wb_data_t) + 1
                           + $bits(wb_sel_t) + 3;
    // Read data plus the ack and err toggle flags.
    localparam int RET_W = $bits(wb_data_t) + 2;

    logic             prev_stb;
    logic             prev_resp;
    logic             ignored_addr;
    logic             m_new_req;
    logic             m_fwd_xfer;
    logic             m_new_req_flag;
    burst_cnt_t       m_burst_cnt;
    logic             m_xor_ack;
    logic             m_xor_err;
    logic             prev_xor_ack;
    logic             prev_xor_err;

    logic             s_newreq_flag;
    logic             prev_newreq_flag;
    logic             s_newreq;
    logic             ack_next_hold;
    burst_cnt_t       s_burst_cnt;
    logic             burst_in_progress;
    logic             s_ack_flag;
    logic             s_err_flag;

    logic [FWD_W-1:0] fwd_word;
    logic [RET_W-1:0] ret_word;

    always_ff @(posedge clk_m) begin
        if (m_rst) begin
            prev_stb  <= 1'b0;
            prev_resp <= 1'b0;
        end else begin
            prev_stb  <= m_wb_stb;
            prev_resp <= m_wb_ack | m_wb_err;
        end
    end

    assign ignored_addr = m_wb_adr < wb_addr_t'(`IGNORED_ADDR_LIMIT);

    // Rising stb, or stb still held right after a completed beat.
    assign m_new_req  = m_wb_cyc & m_wb_stb & (~prev_stb | prev_resp) & ~ignored_addr;
    assign m_fwd_xfer = m_new_req & ~(|m_burst_cnt);

    // Writes are always single beat.
    always_ff @(posedge clk_m) begin
        if (m_rst) begin
            m_new_req_flag <= 1'b0;
            m_burst_cnt    <= '0;
        end else if (m_fwd_xfer) begin
            m_new_req_flag <= ~m_new_req_flag;
            if (m_wb_we) begin
                m_burst_cnt <= burst_cnt_t'(1);
            end else if (m_wb_8_burst) begin
                m_burst_cnt <= burst_cnt_t'(8);
            end else if (m_wb_4_burst) begin
                m_burst_cnt <= burst_cnt_t'(4);
            end else begin
                m_burst_cnt <= burst_cnt_t'(1);
            end
        end else if (m_wb_ack | m_wb_err) begin
            m_burst_cnt <= m_burst_cnt - 1'b1; // One beat done.
        end
    end

    ff_mb_sync #(
        .DATA_W (FWD_W)
    ) i_fwd_sync (
        .src_clk  (clk_m),
        .dst_clk  (clk_s),
        .src_rst  (m_rst),
        .dst_rst  (s_rst),
        .src_data ({m_wb_cyc, m_wb_adr, m_wb_o_dat, m_wb_we, m_wb_sel,
                    m_wb_4_burst, m_wb_8_burst, ~m_new_req_flag}),
        .src_xfer (m_fwd_xfer),
        .dst_data (fwd_word)
    );

    assign {s_wb_cyc, s_wb_adr, s_wb_o_dat, s_wb_we, s_wb_sel,
            s_wb_4_burst, s_wb_8_burst, s_newreq_flag} = fwd_word;

    always_ff @(posedge clk_s) begin
        if (s_rst) begin
            prev_newreq_flag <= 1'b0;
        end else begin
            prev_newreq_flag <= s_newreq_flag;
        end
    end

    assign s_newreq          = prev_newreq_flag ^ s_newreq_flag;
    assign burst_in_progress = |s_burst_cnt;

    // Counts beats left after the current one; hold stops stb after the last.
    always_ff @(posedge clk_s) begin
        if (s_rst) begin
            ack_next_hold <= 1'b0;
            s_burst_cnt   <= '0;
        end else if ((s_wb_ack | s_wb_err) & burst_in_progress) begin
            s_burst_cnt   <= s_burst_cnt - 1'b1;
            ack_next_hold <= 1'b0;
        end else if (s_wb_ack | s_wb_err) begin
            ack_next_hold <= 1'b1;
        end else if (s_newreq) begin
            ack_next_hold <= 1'b0;
            if (s_wb_we) begin
                s_burst_cnt <= '0;
            end else if (s_wb_8_burst) begin
                s_burst_cnt <= burst_cnt_t'(7);
            end else if (s_wb_4_burst) begin
                s_burst_cnt <= burst_cnt_t'(3);
            end else begin
                s_burst_cnt <= '0;
            end
        end
    end

    assign s_wb_stb = s_wb_cyc & ~ack_next_hold;

    always_ff @(posedge clk_s) begin
        if (s_rst) begin
            s_ack_flag <= 1'b0;
            s_err_flag <= 1'b0;
        end else begin
            if (s_wb_ack) s_ack_flag <= ~s_ack_flag;
            if (s_wb_err) s_err_flag <= ~s_err_flag;
        end
    end

    // Carries the flag values that take effect with this beat.
    ff_mb_sync #(
        .DATA_W (RET_W)
    ) i_ret_sync (
        .src_clk  (clk_s),
        .dst_clk  (clk_m),
        .src_rst  (s_rst),
        .dst_rst  (m_rst),
        .src_data ({s_wb_i_dat, s_err_flag ^ s_wb_err, s_ack_flag ^ s_wb_ack}),
        .src_xfer (s_wb_ack | s_wb_err),
        .dst_data (ret_word)
    );

    assign {m_wb_i_dat, m_xor_err, m_xor_ack} = ret_word;

    always_ff @(posedge clk_m) begin
        if (m_rst) begin
            prev_xor_ack <= 1'b0;
            prev_xor_err <= 1'b0;
        end else begin
            prev_xor_ack <= m_xor_ack;
            prev_xor_err <= m_xor_err;
        end
    end

    assign m_wb_ack = prev_xor_ack ^ m_xor_ack; // One clk_m pulse per flag edge.
    assign m_wb_err = prev_xor_err ^ m_xor_err;

endmodule

/* ff_mb_sync.sv */
`timescale 1ns/1ps

// Toggle-flag multibit synchronizer.
// The word is held in src_hold while the flag crosses, so dst_data never
// sees a torn value.
module ff_mb_sync #(
    parameter int DATA_W = 8
) (
    input  logic              src_clk,
    input  logic              dst_clk,
    input  logic              src_rst,
    input  logic              dst_rst,
    input  logic [DATA_W-1:0] src_data,
    input  logic              src_xfer,
    output logic [DATA_W-1:0] dst_data
);

    logic [DATA_W-1:0] src_hold;
    logic              src_flag;
    logic [2:0]        dst_flag; // Two sync stages, then the edge stage.
    logic              dst_load;

    always_ff @(posedge src_clk) begin
        if (src_rst) begin
            src_flag <= 1'b0;
        end else if (src_xfer) begin
            src_flag <= ~src_flag;
        end
    end

    always_ff @(posedge src_clk) begin
        if (src_xfer) begin
            src_hold <= src_data;
        end
    end

    always_ff @(posedge dst_clk) begin
        if (dst_rst) begin
            dst_flag <= '0;
        end else begin
            dst_flag <= {dst_flag[1:0], src_flag};
        end
    end

    assign dst_load = dst_flag[2] ^ dst_flag[1]; // Flag edge after two stages.

    // Loads on the third destination edge after the source toggle.
    always_ff @(posedge dst_clk) begin
        if (dst_rst) begin
            dst_data <= '0;
        end else if (dst_load) begin
            dst_data <= src_hold;
        end
    end

endmodule

/* wb_cdc_pkg.sv */
`include "wb_cdc_config.svh"

package wb_cdc_pkg;

    typedef logic [`WB_ADDR_W-1:0] wb_addr_t;      // Word address.
    typedef logic [`RW-1:0] wb_data_t;             // Data word.
    typedef logic [`SEL_W-1:0] wb_sel_t;           // One bit per byte lane.
    typedef logic [`MAX_BURST_LOG-1:0] burst_cnt_t; // Beat count or offset.

    // Slave memory FSM.
    typedef enum logic [1:0] {
        RAM_IDLE, // Waiting for a strobe.
        RAM_ACK,  // Burst beats in flight.
        RAM_HOLD  // Last beat done, wait for stb to drop.
    } ram_state_t;

endpackage

/* wb_cdc_config.svh */
`ifndef WB_CDC_CONFIG_SVH
`define WB_CDC_CONFIG_SVH

// Bus geometry.
`define WB_ADDR_W 24
`define RW 16
`define SEL_W 2

// Width of the beat counters, enough for an 8-beat read burst.
`define MAX_BURST_LOG 4

// Requests below this word address are never forwarded.
`define IGNORED_ADDR_LIMIT 'h002000

// Slave memory holds 2**RAM_DEPTH_LOG words from IGNORED_ADDR_LIMIT up.
`define RAM_DEPTH_LOG 6

`endif
